// ==== verilog/videoTimingPkg.sv ====
package videoTimingPkg;

	// Width of both the pixel and the raster count
	localparam int countWidth = 9;

	// Frame standard, latched once per frame
	typedef enum logic {
		modeNtsc = 1'b0,
		modePal = 1'b1
	} videoMode;

	// Horizontal timing in pixels
	localparam int pixelsPerLine = 384;
	localparam int hBlankStart = 320;
	localparam int hSyncStart = 336;
	localparam int hSyncEnd = 367;

	// Vertical timing in lines
	localparam int linesNtsc = 264;
	localparam int linesPal = 312;
	localparam int vBlankStart = 224;
	localparam int vSyncStartNtsc = 240;
	localparam int vSyncStartPal = 256;
	localparam int vSyncLength = 3;

	// Terminal counts, sized to the counters
	localparam logic [countWidth-1:0] lastPixel = countWidth'(pixelsPerLine - 1);
	localparam logic [countWidth-1:0] lastLineNtsc = countWidth'(linesNtsc - 1);
	localparam logic [countWidth-1:0] lastLinePal = countWidth'(linesPal - 1);

	// Horizontal compare points
	localparam logic [countWidth-1:0] hBlankFirst = countWidth'(hBlankStart);
	localparam logic [countWidth-1:0] hSyncFirst = countWidth'(hSyncStart);
	localparam logic [countWidth-1:0] hSyncLast = countWidth'(hSyncEnd);

	// Vertical compare points
	localparam logic [countWidth-1:0] vBlankFirst = countWidth'(vBlankStart);
	localparam logic [countWidth-1:0] vSyncFirstNtsc = countWidth'(vSyncStartNtsc);
	localparam logic [countWidth-1:0] vSyncFirstPal = countWidth'(vSyncStartPal);

	// Offset from the first to the last vsync line
	localparam logic [countWidth-1:0] vSyncSpan = countWidth'(vSyncLength - 1);

endpackage

// ==== verilog/videoSignalsPkg.sv ====
package videoSignalsPkg;

	import videoTimingPkg::*;

	// Beam position as seen by the sync decoder and the outside
	typedef struct packed {
		logic [countWidth-1:0] pixel;
		logic [countWidth-1:0] raster;
	} beamPosition;

	// Registered sync and blanking levels, all active high
	typedef struct packed {
		// Line sync pulse
		logic hSync;
		// Frame sync pulse
		logic vSync;
		// Right border and horizontal retrace
		logic hBlank;
		// Bottom border and vertical retrace
		logic vBlank;
		// Mix of both sync pulses for a single-wire sync
		logic compositeSync;
		// Blank for the character layer, either direction
		logic charBlank;
	} syncSignals;

endpackage

// ==== verilog/pixelCounter.sv ====
`timescale 1ns/100ps

module pixelCounter
	import videoTimingPkg::*;
(
	input logic clk24mb,
	input logic reset,
	input logic pixelStrobe,
	output logic [countWidth-1:0] pixel,
	output logic endOfLine
);

	logic atLastPixel;
	logic [countWidth-1:0] pixelNext;

	// Terminal count of the line
	assign atLastPixel = (pixel == lastPixel);

	// Pulse lines up with the wrap edge
	assign endOfLine = pixelStrobe & atLastPixel;

	always_comb begin
		if (atLastPixel) begin
			pixelNext = '0;
		end else begin
			pixelNext = pixel + 1'b1;
		end
	end

	// Advance only on the pixel strobe
	always_ff @(posedge clk24mb) begin
		if (reset) begin
			pixel <= '0;
		end else if (pixelStrobe) begin
			pixel <= pixelNext;
		end
	end

endmodule

// ==== verilog/rasterCounter.sv ====
`timescale 1ns/100ps

module rasterCounter
	import videoTimingPkg::*;
(
	input logic clk24mb,
	input logic reset,
	input logic endOfLine,
	input videoMode mode,
	output logic [countWidth-1:0] raster,
	output videoMode activeMode,
	output logic endOfFrame
);

	logic [countWidth-1:0] lastLine;
	logic atLastLine;

	// Frame length follows the latched mode only
	always_comb begin
		if (activeMode == modePal) begin
			lastLine = lastLinePal;
		end else begin
			lastLine = lastLineNtsc;
		end
	end

	assign atLastLine = (raster == lastLine);

	// Last pixel of the last line
	assign endOfFrame = endOfLine & atLastLine;

	always_ff @(posedge clk24mb) begin
		if (reset) begin
			raster <= '0;
		end else if (endOfFrame) begin
			raster <= '0;
		end else if (endOfLine) begin
			raster <= raster + 1'b1;
		end
	end

	// Mode is sampled in reset and again at each frame wrap
	always_ff @(posedge clk24mb) begin
		if (reset) begin
			activeMode <= mode;
		end else if (endOfFrame) begin
			activeMode <= mode;
		end
	end

endmodule

// ==== verilog/syncGenerator.sv ====
`timescale 1ns/100ps

module syncGenerator
	import videoTimingPkg::*;
	import videoSignalsPkg::*;
(
	input logic clk24mb,
	input logic reset,
	input beamPosition position,
	input videoMode activeMode,
	output syncSignals syncOut
);

	logic [countWidth-1:0] vSyncFirst;
	logic [countWidth-1:0] vSyncLast;
	logic hBlankNext;
	logic hSyncNext;
	logic vBlankNext;
	logic vSyncNext;
	syncSignals syncNext;

	// Vsync window moves with the latched mode
	always_comb begin
		if (activeMode == modePal) begin
			vSyncFirst = vSyncFirstPal;
		end else begin
			vSyncFirst = vSyncFirstNtsc;
		end
		vSyncLast = vSyncFirst + vSyncSpan;
	end

	// Horizontal decode
	always_comb begin
		hBlankNext = (position.pixel >= hBlankFirst);
		hSyncNext = (position.pixel >= hSyncFirst) && (position.pixel <= hSyncLast);
	end

	// Vertical decode
	always_comb begin
		vBlankNext = (position.raster >= vBlankFirst);
		vSyncNext = (position.raster >= vSyncFirst) && (position.raster <= vSyncLast);
	end

	always_comb begin
		syncNext.hSync = hSyncNext;
		syncNext.vSync = vSyncNext;
		syncNext.hBlank = hBlankNext;
		syncNext.vBlank = vBlankNext;
		// Sync pulses invert each other during the frame sync
		syncNext.compositeSync = hSyncNext ^ vSyncNext;
		syncNext.charBlank = hBlankNext | vBlankNext;
	end

	// All six levels change on the same edge
	always_ff @(posedge clk24mb) begin
		if (reset) begin
			syncOut <= '0;
		end else begin
			syncOut <= syncNext;
		end
	end

endmodule

// ==== verilog/videoSync.sv ====
`timescale 1ns/100ps

module videoSync
	import videoTimingPkg::*;
	import videoSignalsPkg::*;
(
	input logic clk24mb,
	input logic reset,
	input logic pixelStrobe,
	input videoMode mode,
	output beamPosition position,
	output syncSignals syncOut,
	output logic endOfFrame
);

	logic endOfLine;
	videoMode activeMode;

	pixelCounter pixelCounter_inst (
		.clk24mb(clk24mb),
		.reset(reset),
		.pixelStrobe(pixelStrobe),
		.pixel(position.pixel),
		.endOfLine(endOfLine)
	);

	// Steps once per line, at the pixel wrap
	rasterCounter rasterCounter_inst (
		.clk24mb(clk24mb),
		.reset(reset),
		.endOfLine(endOfLine),
		.mode(mode),
		.raster(position.raster),
		.activeMode(activeMode),
		.endOfFrame(endOfFrame)
	);

	syncGenerator syncGenerator_inst (
		.clk24mb(clk24mb),
		.reset(reset),
		.position(position),
		.activeMode(activeMode),
		.syncOut(syncOut)
	);

endmodule

// ==== verification/videoSyncTb.sv ====
`timescale 1ns/100ps

module videoSyncTb
	import videoTimingPkg::*;
	import videoSignalsPkg::*;
();

	// Four clk24mb cycles per pixel
	localparam int strobeDivide = 4;
	// Two NTSC and two PAL frames come to about 1.8 million cycles
	localparam int timeoutCycles = 2_500_000;

	logic clk24mb;
	logic reset;
	logic pixelStrobe;
	videoMode mode;
	beamPosition position;
	syncSignals syncOut;
	logic endOfFrame;

	// Reference model
	int expPixel;
	int expRaster;
	videoMode expMode;
	syncSignals expSync;
	int lastRaster;
	int strobePhase;
	videoMode modeRequest;

	// Observed per frame
	int eofCount;
	int eofPixel;
	int eofRaster;
	int rasterMax;
	int vSyncMin;
	int vSyncMax;
	int cycleCount = 0;

	videoSync videoSync_inst (
		.clk24mb(clk24mb),
		.reset(reset),
		.pixelStrobe(pixelStrobe),
		.mode(mode),
		.position(position),
		.syncOut(syncOut),
		.endOfFrame(endOfFrame)
	);

	always #4 clk24mb = ~clk24mb;

	always @(posedge clk24mb) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > timeoutCycles) begin
			reportFailure($sformatf("Timeout: tests did not finish within %0d cycles",
				timeoutCycles));
		end
	end

	function automatic int lastLineOf(input videoMode m);
		return (m == modePal) ? linesPal - 1 : linesNtsc - 1;
	endfunction

	function automatic int frameCycles(input int lines);
		return lines * pixelsPerLine * strobeDivide;
	endfunction

	// Sync levels as the decode rules give them for one position
	function automatic syncSignals expectedSync(input int pixel, input int raster,
		input videoMode m);
		syncSignals s;
		int vStart;
		vStart = (m == modePal) ? vSyncStartPal : vSyncStartNtsc;
		s.hBlank = (pixel >= hBlankStart);
		s.hSync = (pixel >= hSyncStart) && (pixel <= hSyncEnd);
		s.vBlank = (raster >= vBlankStart);
		s.vSync = (raster >= vStart) && (raster < vStart + vSyncLength);
		s.compositeSync = s.hSync ^ s.vSync;
		s.charBlank = s.hBlank | s.vBlank;
		return s;
	endfunction

	task automatic reportFailure(input string message);
		$display("%s", message);
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic checkValue(input string name, input int expected, input int actual);
		assert (actual == expected) else begin
			reportFailure($sformatf("** Error at time %0t: %s expected %0d, actual %0d",
				$time, name, expected, actual));
		end
	endtask

	// One clock edge of the model from the inputs held over the last cycle
	task automatic advanceModel();
		logic eol;
		logic eof;
		eol = pixelStrobe && (expPixel == pixelsPerLine - 1);
		eof = eol && (expRaster == lastLineOf(expMode));
		expSync = expectedSync(expPixel, expRaster, expMode);
		lastRaster = expRaster;
		if (pixelStrobe) begin
			expPixel = eol ? 0 : expPixel + 1;
		end
		if (eol) begin
			expRaster = eof ? 0 : expRaster + 1;
		end
		if (eof) begin
			expMode = mode;
		end
	endtask

	task automatic compareOutputs();
		logic eofNow;
		eofNow = pixelStrobe && (expPixel == pixelsPerLine - 1)
			&& (expRaster == lastLineOf(expMode));
		checkValue("position.pixel", expPixel, int'(position.pixel));
		checkValue("position.raster", expRaster, int'(position.raster));
		checkValue("endOfFrame", int'(eofNow), int'(endOfFrame));
		// Derived levels must agree with the parts beside them
		checkValue("syncOut.compositeSync vs hSync^vSync",
			int'(syncOut.hSync ^ syncOut.vSync), int'(syncOut.compositeSync));
		checkValue("syncOut.charBlank vs hBlank|vBlank",
			int'(syncOut.hBlank | syncOut.vBlank), int'(syncOut.charBlank));
		checkValue("syncOut.hSync", int'(expSync.hSync), int'(syncOut.hSync));
		checkValue("syncOut.vSync", int'(expSync.vSync), int'(syncOut.vSync));
		checkValue("syncOut.hBlank", int'(expSync.hBlank), int'(syncOut.hBlank));
		checkValue("syncOut.vBlank", int'(expSync.vBlank), int'(syncOut.vBlank));
		checkValue("syncOut.compositeSync", int'(expSync.compositeSync),
			int'(syncOut.compositeSync));
		checkValue("syncOut.charBlank", int'(expSync.charBlank), int'(syncOut.charBlank));
	endtask

	task automatic clearStats();
		eofCount = 0;
		eofPixel = -1;
		eofRaster = -1;
		rasterMax = 0;
		vSyncMin = 1000;
		vSyncMax = -1;
	endtask

	task automatic recordStats();
		if (endOfFrame) begin
			eofCount = eofCount + 1;
			eofPixel = int'(position.pixel);
			eofRaster = int'(position.raster);
		end
		if (int'(position.raster) > rasterMax) begin
			rasterMax = int'(position.raster);
		end
		// vSync shows the line of the cycle before
		if (syncOut.vSync) begin
			if (lastRaster < vSyncMin) begin
				vSyncMin = lastRaster;
			end
			if (lastRaster > vSyncMax) begin
				vSyncMax = lastRaster;
			end
		end
	endtask

	task automatic runCycle(input logic allowStrobe);
		@(posedge clk24mb);
		advanceModel();
		#1;
		mode = modeRequest;
		pixelStrobe = allowStrobe && (strobePhase == 0);
		if (allowStrobe) begin
			strobePhase = (strobePhase + 1) % strobeDivide;
		end
		@(negedge clk24mb);
		compareOutputs();
		recordStats();
	endtask

	task automatic runCycles(input int count, input logic allowStrobe);
		repeat (count) begin
			runCycle(allowStrobe);
		end
	endtask

	task automatic applyReset(input videoMode resetMode);
		@(posedge clk24mb);
		#1;
		reset = 1'b1;
		pixelStrobe = 1'b0;
		mode = resetMode;
		modeRequest = resetMode;
		repeat (2) @(posedge clk24mb);
		#1;
		reset = 1'b0;
		expPixel = 0;
		expRaster = 0;
		expMode = resetMode;
		expSync = '0;
		lastRaster = 0;
		strobePhase = 0;
		@(negedge clk24mb);
		compareOutputs();
	endtask

	task automatic verifyFrameStats(input int lines, input int vStart);
		checkValue("endOfFrame pulse count", 1, eofCount);
		checkValue("endOfFrame at pixel", pixelsPerLine - 1, eofPixel);
		checkValue("endOfFrame at raster", lines - 1, eofRaster);
		checkValue("last raster line", lines - 1, rasterMax);
		checkValue("first vSync line", vStart, vSyncMin);
		checkValue("last vSync line", vStart + vSyncLength - 1, vSyncMax);
	endtask

	task automatic verifyResetState();
		applyReset(modeNtsc);
		checkValue("position", 0, int'(position));
		checkValue("syncOut", 0, int'(syncOut));
		checkValue("endOfFrame", 0, int'(endOfFrame));
	endtask

	task automatic ntscFrameTest();
		applyReset(modeNtsc);
		clearStats();
		runCycles(frameCycles(linesNtsc), 1'b1);
		verifyFrameStats(linesNtsc, vSyncStartNtsc);
	endtask

	task automatic palFrameTest();
		applyReset(modePal);
		clearStats();
		runCycles(frameCycles(linesPal), 1'b1);
		verifyFrameStats(linesPal, vSyncStartPal);
	endtask

	// PAL requested halfway takes effect only at the next frame
	task automatic modeChangeTest();
		applyReset(modeNtsc);
		clearStats();
		runCycles(frameCycles(linesNtsc) / 2, 1'b1);
		modeRequest = modePal;
		runCycles(frameCycles(linesNtsc) / 2, 1'b1);
		verifyFrameStats(linesNtsc, vSyncStartNtsc);
		clearStats();
		runCycles(frameCycles(linesPal), 1'b1);
		verifyFrameStats(linesPal, vSyncStartPal);
	endtask

	task automatic strobeGapTest();
		int heldPixel;
		int heldRaster;
		runCycles(strobeDivide * hBlankStart, 1'b1);
		heldPixel = int'(position.pixel);
		heldRaster = int'(position.raster);
		runCycles(13, 1'b0);
		checkValue("held position.pixel", heldPixel, int'(position.pixel));
		checkValue("held position.raster", heldRaster, int'(position.raster));
		runCycles(strobeDivide * 8, 1'b1);
	endtask

	initial begin
		clk24mb = 1'b0;
		reset = 1'b1;
		pixelStrobe = 1'b0;
		mode = modeNtsc;
		modeRequest = modeNtsc;
		verifyResetState();
		ntscFrameTest();
		palFrameTest();
		modeChangeTest();
		strobeGapTest();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== compile.f ====
verilog/videoTimingPkg.sv
verilog/videoSignalsPkg.sv
verilog/pixelCounter.sv
verilog/rasterCounter.sv
verilog/syncGenerator.sv
verilog/videoSync.sv
verification/videoSyncTb.sv

// ==== Makefile ====
# Verilator build and run for the video timing generator

VERILATOR ?= verilator
TOP ?= videoSyncTb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VERILATOR_FLAGS ?= --binary --timing --assert --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only --timing --timescale $(TIMESCALE)
PASS_MSG ?= Simulation finished: PASS

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv verification/*.sv)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
